// File: design/load_pkg.sv
// ROM download definitions
package load_pkg;

	//////////////////////////////////////////////////
	// Download stream
	//////////////////////////////////////////////////

	localparam logic [5:0] rom_index_max = 6'h01; // Indices 0 and 1 carry ROM images
	localparam int         cart_mode_bit = 6;     // Set for cartridge-mode loads

	//////////////////////////////////////////////////
	// Header layout in byte-swapped word offsets
	//////////////////////////////////////////////////

	// Cartridge ID spans six words and the last one triggers the compare
	localparam logic [24:0] hdr_id_addr_first = 25'h000182;
	localparam logic [24:0] hdr_id_addr_last  = 25'h00018C;

	localparam logic [24:0] hdr_region_addr = 25'h0001F0; // Low byte is region letter

	// Known Pier Solar releases
	localparam logic [63:0] pier_id_reprint = "T-574023";
	localparam logic [63:0] pier_id_first   = "T-574013";

	typedef enum logic [1:0] {
		jp = 2'd0,
		us = 2'd1,
		eu = 2'd2
	} region_t;

endpackage

// File: design/mapper_pkg.sv
// Cartridge mapper definitions
package mapper_pkg;

	localparam int bank_count = 8;
	localparam int bank_w     = 5; // Bank number width

	typedef logic [23:13] rom_mask_t; // ROM size mask in 8 KB steps

	//////////////////////////////////////////////////
	// Paging write word
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [15-bank_w:0] pad;
		logic [bank_w-1:0]  num;
	} page_bank_t;

	typedef struct packed {
		logic [11:0] pad;
		logic        cs;   // Active-low EEPROM chip select
		logic        hold; // Active-low hold
		logic        sck;
		logic        si;
	} page_eeprom_t;

	// Same data word as a bank write or an EEPROM pin write
	typedef union packed {
		page_bank_t   bank;
		page_eeprom_t eeprom;
	} page_data_u;

	// Paging register offsets (address bits 3:1)
	localparam logic [2:0] page_reg_eeprom      = 3'd4;
	localparam logic [2:0] page_reg_eeprom_read = 3'd5;

	// Protection check words
	localparam logic [23:0] pier_hook_addr_a = 24'h0015E6;
	localparam logic [23:0] pier_hook_addr_b = 24'h0015E8;
	localparam int          pier_hook_limit  = 6; // Reads before the answer changes

endpackage

// File: design/cart_ifs.sv
// Cartridge info and console bus interfaces
`timescale 1ns/1ns

// Results of the header snoop shared by the mapper blocks
interface cart_info_if
	import mapper_pkg::*;
();
	logic      rom_download;
	logic      rom_cart_mode;
	rom_mask_t rom_mask;
	logic      pier_quirk;

	modport source (
		output rom_download,
		output rom_cart_mode,
		output rom_mask,
		output pier_quirk
	);

	modport sink (
		input rom_download,
		input rom_cart_mode,
		input rom_mask,
		input pier_quirk
	);
endinterface

// Console side of the cartridge slot
interface cart_bus_if ();
	logic [23:1] gen_va;
	logic [15:0] gen_vdo;
	logic        gen_rnw;
	logic        page_ce_n; // Paging window select
	logic        asel_n;    // Address strobe

	modport monitor (
		input gen_va,
		input gen_vdo,
		input gen_rnw,
		input page_ce_n,
		input asel_n
	);
endinterface

// File: design/rom_header_snoop.sv
// ROM header snoop
`timescale 1ns/1ns

module rom_header_snoop
	import load_pkg::*;
	import mapper_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_data,
	cart_info_if.source info,
	output region_t     region_req
);

	logic        rom_download;
	logic        cart_wr;
	logic        id_in_range;
	logic [2:0]  id_slot;
	logic [15:0] data_swap;

	rom_mask_t   rom_mask;
	logic        rom_cart_mode;
	logic        pier_quirk;
	logic        old_download;
	logic [63:0] cart_id;

	assign rom_download = ioctl_download & (ioctl_index[5:0] <= rom_index_max);
	assign cart_wr      = rom_download & ioctl_wr & ioctl_index[cart_mode_bit];
	assign data_swap    = {ioctl_data[7:0], ioctl_data[15:8]};

	// ID words sit on even offsets between first and last
	assign id_in_range = ~ioctl_addr[0] &
		(ioctl_addr >= hdr_id_addr_first) & (ioctl_addr <= hdr_id_addr_last);
	assign id_slot = ioctl_addr[3:1] - hdr_id_addr_first[3:1];

	//////////////////////////////////////////////////
	// Mode, size mask and region
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask      <= '0;
			rom_cart_mode <= 1'b0;
			region_req    <= jp;
		end else if (rom_download & ioctl_wr) begin
			rom_cart_mode <= ioctl_index[cart_mode_bit];
			if (ioctl_index[cart_mode_bit]) begin
				if (ioctl_addr == '0)
					rom_mask <= '0; // New image starts
				else
					rom_mask <= rom_mask | ioctl_addr[23:13];
			end
			if (ioctl_addr == hdr_region_addr) begin
				case (ioctl_data[7:0])
					"J":     region_req <= jp;
					"U":     region_req <= us;
					default: region_req <= eu;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Cartridge ID and Pier quirk
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (cart_wr & id_in_range) begin
			case (id_slot)
				3'd0: cart_id[63:56] <= ioctl_data[15:8];
				3'd1: cart_id[55:40] <= data_swap;
				3'd2: cart_id[39:24] <= data_swap;
				3'd3: cart_id[23:8]  <= data_swap;
				3'd4: cart_id[7:0]   <= ioctl_data[7:0];
				default: ;            // Compare slot
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			pier_quirk   <= 1'b0;
		end else begin
			old_download <= rom_download;
			if (~old_download & rom_download)
				pier_quirk <= 1'b0;
			// Whole ID is in place once the last word arrives
			if (cart_wr && ioctl_addr == hdr_id_addr_last)
				if (cart_id == pier_id_reprint || cart_id == pier_id_first)
					pier_quirk <= 1'b1;
		end
	end

	assign info.rom_download  = rom_download;
	assign info.rom_cart_mode = rom_cart_mode;
	assign info.rom_mask      = rom_mask;
	assign info.pier_quirk    = pier_quirk;

endmodule

// File: design/bank_mapper.sv
// Bank registers and Pier EEPROM pins
`timescale 1ns/1ns

module bank_mapper
	import mapper_pkg::*;
#(
	parameter int bank_count = mapper_pkg::bank_count
) (
	input  logic        clk_sys,
	input  logic        reset,
	cart_info_if.sink   info,
	cart_bus_if.monitor bus,
	input  logic        ep_so,
	output logic        ep_cs,
	output logic        ep_hold,
	output logic        ep_sck,
	output logic        ep_si,
	output logic [15:0] page_di,
	output logic [23:1] rom_va
);

	logic [bank_w-1:0] bank_reg [bank_count];
	logic              old_ce;
	logic              page_edge;
	logic [2:0]        reg_ofs;
	page_data_u        page_word;

	assign page_edge = old_ce & ~bus.page_ce_n; // Falling edge of the window select
	assign reg_ofs   = bus.gen_va[3:1];
	assign page_word = bus.gen_vdo;

	always_ff @(posedge clk_sys) begin
		if (reset)
			old_ce <= 1'b1;
		else
			old_ce <= bus.page_ce_n;
	end

	//////////////////////////////////////////////////
	// Paging window accesses
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset | info.rom_download) begin
			for (int i = 0; i < bank_count; i++)
				bank_reg[i] <= bank_w'(i); // Identity mapping
			if (reset)
				{ep_cs, ep_hold, ep_sck, ep_si} <= 4'b0000;
		end else if (page_edge) begin
			page_di <= '1;
			if (info.pier_quirk) begin
				if (bus.gen_rnw) begin
					if (reg_ofs == page_reg_eeprom_read)
						page_di[0] <= ep_so;
				end else if (reg_ofs == page_reg_eeprom) begin
					ep_cs   <= page_word.eeprom.cs;
					ep_hold <= page_word.eeprom.hold;
					ep_sck  <= page_word.eeprom.sck;
					ep_si   <= page_word.eeprom.si;
				end else if (reg_ofs != 3'd0 && !reg_ofs[2]) begin
					// Offsets 1 to 3 remap the upper windows 5 to 7
					bank_reg[{1'b1, reg_ofs[1:0]}] <= {1'b0, page_word.bank.num[3:0]};
				end
			end else if (info.rom_mask[23:22] != 2'b00) begin // Above 4 MB
				if (!bus.gen_rnw && reg_ofs != 3'd0)
					bank_reg[reg_ofs] <= page_word.bank.num;
			end
		end
	end

	//////////////////////////////////////////////////
	// ROM address
	//////////////////////////////////////////////////

	// Window from address bits 21:19, then clipped to the image size
	assign rom_va = {bank_reg[bus.gen_va[21:19]], bus.gen_va[18:1]} &
		{info.rom_mask, 12'hFFF};

endmodule

// File: design/pier_read_hook.sv
// Pier protection read hook
`timescale 1ns/1ns

module pier_read_hook
	import mapper_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	cart_info_if.sink   info,
	cart_bus_if.monitor bus,
	output logic        hook_active,
	output logic [15:0] hook_data
);

	logic       old_sel;
	logic       sel_edge;
	logic       hook_hit;
	logic [3:0] hook_count;

	assign sel_edge = old_sel & ~bus.asel_n;
	assign hook_hit = ({bus.gen_va, 1'b0} == pier_hook_addr_a) ||
		({bus.gen_va, 1'b0} == pier_hook_addr_b);

	always_ff @(posedge clk_sys) begin
		if (reset)
			old_sel <= 1'b1;
		else
			old_sel <= bus.asel_n;
	end

	always_ff @(posedge clk_sys) begin
		if (reset | info.rom_download) begin
			hook_count  <= '0;
			hook_active <= 1'b0;
		end else if (info.pier_quirk & sel_edge) begin
			hook_active <= 1'b0; // Any other address goes to ROM
			if (hook_hit) begin
				hook_active <= 1'b1;
				if (hook_count < 4'(pier_hook_limit)) begin
					hook_count <= hook_count + 4'd1;
					hook_data  <= bus.gen_va[1] ? 16'h0000 : 16'h0010;
				end else begin
					// Answer expected once the check has settled
					hook_data <= bus.gen_va[1] ? 16'h0001 : 16'h8010;
				end
			end
		end
	end

endmodule

// File: design/cart_mapper_top.sv
// Cartridge mapper front end
`timescale 1ns/1ns

module cart_mapper_top
	import load_pkg::*;
#(
	parameter int bank_count = mapper_pkg::bank_count
) (
	input  logic        clk_sys,
	input  logic        reset,

	// ROM download stream
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_data,

	// Console bus
	input  logic [23:1] gen_va,
	input  logic [15:0] gen_vdo,
	input  logic        gen_rnw,
	input  logic        page_ce_n,
	input  logic        asel_n,
	input  logic [15:0] mem_do,
	input  logic        ep_so,

	output logic [23:1] rom_va,
	output logic [15:0] page_di,
	output logic [15:0] rom_di,
	output logic        ep_cs,
	output logic        ep_hold,
	output logic        ep_sck,
	output logic        ep_si,
	output logic        pier_quirk,
	output logic        rom_cart_mode,
	output region_t     region_req
);

	logic        hook_active;
	logic [15:0] hook_data;

	cart_info_if info_if ();
	cart_bus_if  bus_if ();

	assign bus_if.gen_va    = gen_va;
	assign bus_if.gen_vdo   = gen_vdo;
	assign bus_if.gen_rnw   = gen_rnw;
	assign bus_if.page_ce_n = page_ce_n;
	assign bus_if.asel_n    = asel_n;

	//////////////////////////////////////////////////
	// Mapper blocks
	//////////////////////////////////////////////////

	rom_header_snoop snoop_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.info           (info_if.source),
		.region_req     (region_req)
	);

	bank_mapper #(
		.bank_count (bank_count)
	) mapper_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.info    (info_if.sink),
		.bus     (bus_if.monitor),
		.ep_so   (ep_so),
		.ep_cs   (ep_cs),
		.ep_hold (ep_hold),
		.ep_sck  (ep_sck),
		.ep_si   (ep_si),
		.page_di (page_di),
		.rom_va  (rom_va)
	);

	pier_read_hook hook_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.info        (info_if.sink),
		.bus         (bus_if.monitor),
		.hook_active (hook_active),
		.hook_data   (hook_data)
	);

	assign rom_di        = hook_active ? hook_data : mem_do; // Hook overrides ROM data
	assign pier_quirk    = info_if.pier_quirk;
	assign rom_cart_mode = info_if.rom_cart_mode;

endmodule

// File: sim/cart_checker.sv
// Mapper response checker
`timescale 1ns/1ns

module cart_checker (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        check_en,
	input  logic [3:0]  exp_sel,
	input  logic [31:0] exp_value,
	input  logic [23:1] rom_va,
	input  logic [15:0] rom_di,
	input  logic [15:0] page_di,
	input  logic        pier_quirk,
	input  logic        rom_cart_mode,
	input  logic [1:0]  region_req,
	input  logic        ep_cs,
	input  logic        ep_hold,
	input  logic        ep_sck,
	input  logic        ep_si,
	output int          check_count,
	output int          error_count
);

	logic [31:0] actual;

	function automatic string signal_name(input logic [3:0] sel);
		case (sel)
			4'd0:    return "rom_va";
			4'd1:    return "rom_di";
			4'd2:    return "page_di";
			4'd3:    return "pier_quirk";
			4'd4:    return "rom_cart_mode";
			4'd5:    return "region_req";
			4'd6:    return "EEPROM pins";
			default: return "unknown selector";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Observed value for the selected signal
	//////////////////////////////////////////////////

	always_comb begin
		case (exp_sel)
			4'd0:    actual = {8'h00, rom_va, 1'b0}; // As a byte address
			4'd1:    actual = {16'h0000, rom_di};
			4'd2:    actual = {16'h0000, page_di};
			4'd3:    actual = {31'd0, pier_quirk};
			4'd4:    actual = {31'd0, rom_cart_mode};
			4'd5:    actual = {30'd0, region_req};
			4'd6:    actual = {28'd0, ep_cs, ep_hold, ep_sck, ep_si};
			default: actual = 32'hFFFF_FFFF;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			check_count <= 0;
			error_count <= 0;
		end else if (check_en) begin
			check_count <= check_count + 1;
			if (actual !== exp_value) begin
				error_count <= error_count + 1;
				$display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
					$time, signal_name(exp_sel), actual, exp_value);
			end
		end
	end

endmodule

// File: sim/tb_cart_mapper.sv
// Cartridge mapper testbench
`timescale 1ns/1ns

module tb_cart_mapper;

	localparam logic [3:0] op_load    = 4'h1;
	localparam logic [3:0] op_page_wr = 4'h2;
	localparam logic [3:0] op_page_rd = 4'h3;
	localparam logic [3:0] op_bus_rd  = 4'h4;
	localparam logic [3:0] op_expect  = 4'h5;
	localparam int         case_max   = 128;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic [23:1] gen_va;
	logic [15:0] gen_vdo;
	logic        gen_rnw;
	logic        page_ce_n;
	logic        asel_n;
	logic [15:0] mem_do;
	logic        ep_so;

	logic [23:1] rom_va;
	logic [15:0] page_di;
	logic [15:0] rom_di;
	logic        ep_cs;
	logic        ep_hold;
	logic        ep_sck;
	logic        ep_si;
	logic        pier_quirk;
	logic        rom_cart_mode;
	logic [1:0]  region_req;

	logic        check_en;
	logic [3:0]  exp_sel;
	logic [31:0] exp_value;
	int          check_count;
	int          error_count;

	logic [63:0] cases [case_max]; // op, sel, index, address, data
	int          case_count = 0;
	int          bad_ops;
	logic        in_download;

	always #2 clk_sys = ~clk_sys;

	cart_mapper_top dut_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.gen_va         (gen_va),
		.gen_vdo        (gen_vdo),
		.gen_rnw        (gen_rnw),
		.page_ce_n      (page_ce_n),
		.asel_n         (asel_n),
		.mem_do         (mem_do),
		.ep_so          (ep_so),
		.rom_va         (rom_va),
		.page_di        (page_di),
		.rom_di         (rom_di),
		.ep_cs          (ep_cs),
		.ep_hold        (ep_hold),
		.ep_sck         (ep_sck),
		.ep_si          (ep_si),
		.pier_quirk     (pier_quirk),
		.rom_cart_mode  (rom_cart_mode),
		.region_req     (region_req)
	);

	cart_checker check_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.check_en      (check_en),
		.exp_sel       (exp_sel),
		.exp_value     (exp_value),
		.rom_va        (rom_va),
		.rom_di        (rom_di),
		.page_di       (page_di),
		.pier_quirk    (pier_quirk),
		.rom_cart_mode (rom_cart_mode),
		.region_req    (region_req),
		.ep_cs         (ep_cs),
		.ep_hold       (ep_hold),
		.ep_sck        (ep_sck),
		.ep_si         (ep_si),
		.check_count   (check_count),
		.error_count   (error_count)
	);

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic load_word(input logic [7:0] index, input logic [24:0] addr,
		input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		ioctl_addr     <= addr;
		ioctl_data     <= data;
		ioctl_wr       <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		in_download = 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		in_download = 1'b0;
	endtask

	// Strobe low for two cycles, then high for two
	task automatic run_access(input logic page, input logic rnw, input logic [23:0] addr,
		input logic [15:0] data, input logic chk, input logic [3:0] sel,
		input logic [31:0] value);
		@(posedge clk_sys);
		gen_va  <= addr[23:1];
		gen_rnw <= rnw;
		gen_vdo <= data;
		mem_do  <= data;
		ep_so   <= data[0];
		if (page)
			page_ce_n <= 1'b0;
		else
			asel_n <= 1'b0;
		@(posedge clk_sys);
		check_en  <= chk; // Sampled on the second low cycle
		exp_sel   <= sel;
		exp_value <= value;
		@(posedge clk_sys);
		check_en  <= 1'b0;
		page_ce_n <= 1'b1;
		asel_n    <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic check_now(input logic [3:0] sel, input logic [31:0] value);
		@(posedge clk_sys);
		check_en  <= 1'b1;
		exp_sel   <= sel;
		exp_value <= value;
		@(posedge clk_sys);
		check_en <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Case file driver
	//////////////////////////////////////////////////

	initial begin
		logic [63:0] rec;
		logic [3:0]  op;
		logic        chk;
		logic [3:0]  sel;
		logic [31:0] value;
		int          i;
		int          nxt;
		int          n;

		reset          <= 1'b1;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'h00;
		ioctl_wr       <= 1'b0;
		ioctl_addr     <= '0;
		ioctl_data     <= 16'h0000;
		gen_va         <= '0;
		gen_vdo        <= 16'h0000;
		gen_rnw        <= 1'b1;
		page_ce_n      <= 1'b1;
		asel_n         <= 1'b1;
		mem_do         <= 16'h0000;
		ep_so          <= 1'b0;
		check_en       <= 1'b0;
		exp_sel        <= 4'h0;
		exp_value      <= '0;
		in_download = 1'b0;
		bad_ops = 0;

		for (n = 0; n < case_max; n++)
			cases[n[6:0]] = '0;
		$readmemh("sim/mapper_cases.txt", cases);
		n = 0;
		while (n < case_max && cases[n[6:0]][63:60] != 4'h0)
			n++;
		case_count = n;
		if (case_count == 0) begin
			$display("No cases read from sim/mapper_cases.txt");
			bad_ops = 1;
		end

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		i = 0;
		while (i < case_count) begin
			rec   = cases[i[6:0]];
			op    = rec[63:60];
			chk   = 1'b0;
			sel   = 4'h0;
			value = '0;
			if (op != op_load && in_download)
				end_download();
			// An expect right after an access belongs to it
			nxt = i + 1;
			if (op inside {op_page_wr, op_page_rd, op_bus_rd} && nxt < case_count) begin
				if (cases[nxt[6:0]][63:60] == op_expect) begin
					chk   = 1'b1;
					sel   = cases[nxt[6:0]][59:56];
					value = cases[nxt[6:0]][47:16];
					i = nxt;
				end
			end
			case (op)
				op_load:    load_word(rec[55:48], rec[40:16], rec[15:0]);
				op_page_wr: run_access(1'b1, 1'b0, rec[39:16], rec[15:0], chk, sel, value);
				op_page_rd: run_access(1'b1, 1'b1, rec[39:16], rec[15:0], chk, sel, value);
				op_bus_rd:  run_access(1'b0, 1'b1, rec[39:16], rec[15:0], chk, sel, value);
				op_expect:  check_now(rec[59:56], rec[47:16]);
				default: begin
					$display("Unknown operation %0h in case record %0d", op, i);
					bad_ops++;
				end
			endcase
			i++;
		end
		if (in_download)
			end_download();
		repeat (4) @(posedge clk_sys);

		$display("Checks: %0d, errors: %0d, bad case records: %0d",
			check_count, error_count, bad_ops);
		if (error_count == 0 && bad_ops == 0 && check_count > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Watchdog sized by the number of case records
	initial begin
		wait (case_count > 0);
		repeat (case_count * 20 + 100) @(posedge clk_sys);
		$display("Timeout: cases did not finish within %0d cycles", case_count * 20 + 100);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sim/mapper_cases.txt
// Columns op_sel_index_address_data. Ops: 1 load, 2 paging write, 3 paging read (data bit 0 is
// ep_so), 4 bus read (data is mem_do), 5 expect (value in address column). Selectors: 0 rom_va
// byte address, 1 rom_di, 2 page_di, 3 pier_quirk, 4 rom_cart_mode, 5 region_req, 6 EEPROM pins
// 4 MB cartridge, region U, bank writes ignored
1_0_40_00000000_1234
1_0_40_000001F0_0055
1_0_40_003FFFFE_0000
5_4_00_00000001_0000
5_5_00_00000001_0000
2_0_00_00A130F2_0009
4_0_00_00080000_BEEF
5_0_00_00080000_0000
// 8 MB cartridge, region E, banks 2 and 3 remapped
1_0_40_00000000_0000
1_0_40_000001F0_0045
1_0_40_007FFFFE_0000
5_5_00_00000002_0000
2_0_00_00A130F4_000B
4_0_00_00101234_0000
5_0_00_00581234_0000
2_0_00_00A130F6_001F
4_0_00_00180002_0000
5_0_00_00780002_0000
// Pier Solar reprint, ID T-574023, region J
1_0_40_00000000_0000
1_0_40_00000182_5420
1_0_40_00000184_352D
1_0_40_00000186_3437
1_0_40_00000188_3230
1_0_40_0000018A_2033
1_0_40_0000018C_0000
1_0_40_000001F0_004A
1_0_40_007FFFFE_0000
5_3_00_00000001_0000
5_5_00_00000000_0000
// Window 5 remap, EEPROM pins and data read
2_0_00_00A130F2_0003
4_0_00_00280010_0000
5_0_00_00180010_0000
2_0_00_00A130F8_000B
5_6_00_0000000B_0000
3_0_00_00A130FA_0000
5_2_00_0000FFFE_0000
3_0_00_00A130FA_0001
5_2_00_0000FFFF_0000
// Protection reads, six counted then the settled answer
4_0_00_000015E6_1111
5_1_00_00000000_0000
4_0_00_000015E8_1111
5_1_00_00000010_0000
4_0_00_000015E6_1111
4_0_00_000015E8_1111
4_0_00_000015E6_1111
4_0_00_000015E8_1111
4_0_00_000015E6_1111
5_1_00_00000001_0000
4_0_00_000015E8_1111
5_1_00_00008010_0000
4_0_00_00002000_5A5A
5_1_00_00005A5A_0000
// A new download clears the quirk
1_0_40_00000000_0000
5_3_00_00000000_0000

// File: list.f
design/load_pkg.sv
design/mapper_pkg.sv
design/cart_ifs.sv
design/rom_header_snoop.sv
design/bank_mapper.sv
design/pier_read_hook.sv
design/cart_mapper_top.sv
sim/cart_checker.sv
sim/tb_cart_mapper.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cart_mapper -f list.f -o tb_cart_mapper
./obj_dir/tb_cart_mapper | tee sim.log

if grep -qxF '*** PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
